// ==== lc4_pkg.sv ====
// ##########################################################################
// Shared LC4 pipeline definitions: word, register-select, opcode and
// bypass-select types, opcode and sub-op codes, reset PC and NOP encoding
// ##########################################################################

package lc4_pkg;

   // Field layout of an instruction
   //   [15:12] opcode
   //   [11:9]  rd, or the data register of STR, or rs of HICONST
   //   [8:6]   rs, the base register of LDR and STR
   //   [5:3]   sub-op of arith and logic, [5:4] sub-op of shifts
   //   [2:0]   rt of register-register forms

   typedef logic [15:0] word_t;     // Data, address, PC or instruction
   typedef logic [2:0]  reg_sel_t;  // Register index r0..r7
   typedef logic [3:0]  opcode_t;   // Bits 15:12
   typedef logic [1:0]  fwd_sel_t;  // Execute operand source

   // Execute operand sources
   localparam fwd_sel_t FWD_NONE = 2'd0;  // Value read in decode
   localparam fwd_sel_t FWD_MEM  = 2'd1;  // ALU result in memory stage
   localparam fwd_sel_t FWD_WB   = 2'd2;  // Writeback data

   // Opcodes of the supported subset
   localparam opcode_t OP_ARITH   = 4'b0001;
   localparam opcode_t OP_LOGIC   = 4'b0101;
   localparam opcode_t OP_LDR     = 4'b0110;
   localparam opcode_t OP_STR     = 4'b0111;
   localparam opcode_t OP_CONST   = 4'b1001;
   localparam opcode_t OP_SHIFT   = 4'b1010;
   localparam opcode_t OP_HICONST = 4'b1101;

   // Bit 5 set selects the 5-bit immediate form of ADD and AND
   localparam int IMM_BIT = 5;

   // Arithmetic sub-ops, bits 5:3
   localparam logic [2:0] ARITH_ADD = 3'b000;
   localparam logic [2:0] ARITH_MUL = 3'b001;
   localparam logic [2:0] ARITH_SUB = 3'b010;

   // Logic sub-ops, bits 5:3
   localparam logic [2:0] LOGIC_AND = 3'b000;
   localparam logic [2:0] LOGIC_NOT = 3'b001;
   localparam logic [2:0] LOGIC_OR  = 3'b010;
   localparam logic [2:0] LOGIC_XOR = 3'b011;

   // Shift sub-ops, bits 5:4
   localparam logic [1:0] SHIFT_SLL = 2'b00;
   localparam logic [1:0] SHIFT_SRA = 2'b01;
   localparam logic [1:0] SHIFT_SRL = 2'b10;

   localparam word_t PC_RESET = 16'h8200;  // First fetch address
   localparam word_t NOP_INSN = 16'h0000;  // Opcode 0000 is outside the subset

endpackage

// ==== lc4_decoder.sv ====
// ##########################################################################
// LC4 decoder: register selects, read enables, write enable, load/store
// ##########################################################################

`timescale 1ns/10ps

module lc4_decoder import lc4_pkg::*; (
   input  word_t    i_insn,
   output reg_sel_t o_r1sel,       // rs, or rd for HICONST
   output reg_sel_t o_r2sel,       // rt, or data register for STR
   output reg_sel_t o_wsel,
   output logic     o_r1re,
   output logic     o_r2re,
   output logic     o_regfile_we,
   output logic     o_is_load,
   output logic     o_is_store
);

   opcode_t    opcode;
   logic [2:0] sub_op;
   logic [1:0] shift_op;
   logic       imm_form;
   logic       arith_ok;             // DIV is not supported
   logic       shift_ok;             // MOD is not supported

   assign opcode   = i_insn[15:12];
   assign sub_op   = i_insn[5:3];
   assign shift_op = i_insn[5:4];
   assign imm_form = i_insn[IMM_BIT];
   assign arith_ok = imm_form || (sub_op inside {ARITH_ADD, ARITH_MUL, ARITH_SUB});
   assign shift_ok = shift_op inside {SHIFT_SLL, SHIFT_SRA, SHIFT_SRL};

   always_comb begin
      // Default is a NOP, selects follow the usual fields
      o_r1sel      = i_insn[8:6];
      o_r2sel      = i_insn[2:0];
      o_wsel       = i_insn[11:9];
      o_r1re       = 1'b0;
      o_r2re       = 1'b0;
      o_regfile_we = 1'b0;
      o_is_load    = 1'b0;
      o_is_store   = 1'b0;
      case (opcode)
         OP_ARITH: begin
            o_r1re       = arith_ok;
            o_r2re       = arith_ok && !imm_form;
            o_regfile_we = arith_ok;
         end
         OP_LOGIC: begin
            o_r1re       = 1'b1;
            o_r2re       = !imm_form && (sub_op != LOGIC_NOT);  // NOT has one source
            o_regfile_we = 1'b1;
         end
         OP_SHIFT: begin
            o_r1re       = shift_ok;         // Amount is immediate
            o_regfile_we = shift_ok;
         end
         OP_LDR: begin
            o_r1re       = 1'b1;             // Base
            o_regfile_we = 1'b1;
            o_is_load    = 1'b1;
         end
         OP_STR: begin
            o_r1re       = 1'b1;             // Base
            o_r2re       = 1'b1;             // Data
            o_r2sel      = i_insn[11:9];
            o_is_store   = 1'b1;
         end
         OP_CONST: o_regfile_we = 1'b1;      // No sources
         OP_HICONST: begin
            // Low byte comes from the destination itself
            o_r1sel      = i_insn[11:9];
            o_r1re       = 1'b1;
            o_regfile_we = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

// ==== lc4_regfile.sv ====
// ##########################################################################
// Eight-entry register file, two read ports, write-before-read bypass
// ##########################################################################

`timescale 1ns/10ps

module lc4_regfile import lc4_pkg::*; (
   input  logic     gwe,
   input  logic     i_arst_n,
   input  reg_sel_t i_rs,
   input  reg_sel_t i_rt,
   input  reg_sel_t i_rd,          // Writeback destination
   input  word_t    i_wdata,
   input  logic     i_rd_we,
   output word_t    o_rs_data,
   output word_t    o_rt_data
);

   word_t regs [8];

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // Same-cycle write is seen by decode
   assign o_rs_data = (i_rd_we && (i_rd == i_rs)) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_rd_we && (i_rd == i_rt)) ? i_wdata : regs[i_rt];

   // Writeback must never hand over an unknown destination or value
   a_known_write: assert property (
      @(posedge gwe) disable iff (!i_arst_n)
      i_rd_we |-> !$isunknown({i_rd, i_wdata})
   ) else $error("Register write with unknown index or data");

endmodule

// ==== lc4_alu.sv ====
// ##########################################################################
// LC4 ALU: arithmetic, logic, shifts, constants and load/store address
// ##########################################################################

`timescale 1ns/10ps

module lc4_alu import lc4_pkg::*; (
   input  word_t i_insn,
   input  word_t i_r1data,         // rs, base, or rd of HICONST
   input  word_t i_r2data,         // rt
   output word_t o_result
);

   opcode_t    opcode;
   logic [2:0] sub_op;
   logic [1:0] shift_op;
   logic [3:0] shamt;
   word_t      imm5;
   word_t      imm6;
   word_t      imm9;

   assign opcode   = i_insn[15:12];
   assign sub_op   = i_insn[5:3];
   assign shift_op = i_insn[5:4];
   assign shamt    = i_insn[3:0];

   // Sign-extended immediates
   assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
   assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
   assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

   always_comb begin
      o_result = '0;                 // Unsupported ops give zero
      case (opcode)
         OP_ARITH: begin
            if (i_insn[IMM_BIT]) begin
               o_result = i_r1data + imm5;
            end else begin
               case (sub_op)
                  ARITH_ADD: o_result = i_r1data + i_r2data;
                  ARITH_MUL: o_result = i_r1data * i_r2data;   // Low 16 bits
                  ARITH_SUB: o_result = i_r1data - i_r2data;
                  default:   o_result = '0;
               endcase
            end
         end
         OP_LOGIC: begin
            if (i_insn[IMM_BIT]) begin
               o_result = i_r1data & imm5;
            end else begin
               case (sub_op)
                  LOGIC_AND: o_result = i_r1data & i_r2data;
                  LOGIC_NOT: o_result = ~i_r1data;
                  LOGIC_OR:  o_result = i_r1data | i_r2data;
                  LOGIC_XOR: o_result = i_r1data ^ i_r2data;
                  default:   o_result = '0;
               endcase
            end
         end
         OP_SHIFT: begin
            case (shift_op)
               SHIFT_SLL: o_result = i_r1data << shamt;
               SHIFT_SRA: o_result = $signed(i_r1data) >>> shamt;   // Keeps sign
               SHIFT_SRL: o_result = i_r1data >> shamt;
               default:   o_result = '0;
            endcase
         end
         OP_LDR, OP_STR: o_result = i_r1data + imm6;   // Effective address
         OP_CONST:       o_result = imm9;
         OP_HICONST:     o_result = {i_insn[7:0], i_r1data[7:0]};
         default:        o_result = '0;
      endcase
   end

endmodule

// ==== lc4_hazard_unit.sv ====
// ##########################################################################
// Load-use stall detection and bypass source selection
// ##########################################################################

`timescale 1ns/10ps

module lc4_hazard_unit import lc4_pkg::*; (
   input  logic     gwe,
   input  logic     i_arst_n,
   // Decode
   input  reg_sel_t i_d_r1sel,
   input  reg_sel_t i_d_r2sel,
   input  logic     i_d_r1re,
   input  logic     i_d_r2re,
   input  logic     i_d_is_store,
   // Execute
   input  reg_sel_t i_x_r1sel,
   input  reg_sel_t i_x_r2sel,
   input  reg_sel_t i_x_wsel,
   input  logic     i_x_r1re,
   input  logic     i_x_r2re,
   input  logic     i_x_is_load,
   // Memory
   input  reg_sel_t i_m_r2sel,
   input  reg_sel_t i_m_wsel,
   input  logic     i_m_regfile_we,
   input  logic     i_m_is_load,
   input  logic     i_m_is_store,
   // Writeback
   input  reg_sel_t i_w_wsel,
   input  logic     i_w_regfile_we,
   output logic     o_stall,
   output fwd_sel_t o_rs_fwd,
   output fwd_sel_t o_rt_fwd,
   output logic     o_store_fwd_wb  // Store data from writeback
);

   logic rs_from_mem, rt_from_mem;
   logic rs_from_wb, rt_from_wb;

   // Store data of a load result is picked up later in memory stage
   assign o_stall = i_x_is_load &&
                    ((i_d_r1re && (i_d_r1sel == i_x_wsel)) ||
                     (i_d_r2re && !i_d_is_store && (i_d_r2sel == i_x_wsel)));

   // rs never matches a load in memory, the stall sees to that
   assign rs_from_mem = i_x_r1re && i_m_regfile_we && (i_x_r1sel == i_m_wsel);
   assign rt_from_mem = i_x_r2re && i_m_regfile_we && !i_m_is_load &&
                        (i_x_r2sel == i_m_wsel);
   assign rs_from_wb  = i_x_r1re && i_w_regfile_we && (i_x_r1sel == i_w_wsel);
   assign rt_from_wb  = i_x_r2re && i_w_regfile_we && (i_x_r2sel == i_w_wsel);

   // Youngest producer wins
   assign o_rs_fwd = rs_from_mem ? FWD_MEM : (rs_from_wb ? FWD_WB : FWD_NONE);
   assign o_rt_fwd = rt_from_mem ? FWD_MEM : (rt_from_wb ? FWD_WB : FWD_NONE);

   assign o_store_fwd_wb = i_m_is_store && i_w_regfile_we && (i_m_r2sel == i_w_wsel);

   // The bubble removes the load from execute, so no second stall follows
   a_single_stall: assert property (
      @(posedge gwe) disable iff (!i_arst_n)
      o_stall |=> !o_stall
   ) else $error("Load-use stall lasted more than one cycle");

   // Load data is not ready in memory stage
   a_no_load_mx: assert property (
      @(posedge gwe) disable iff (!i_arst_n)
      ((o_rs_fwd == FWD_MEM) || (o_rt_fwd == FWD_MEM)) |-> !i_m_is_load
   ) else $error("Memory-to-execute bypass taken from a load");

endmodule

// ==== lc4_processor.sv ====
// ##########################################################################
// Five-stage LC4 pipeline top level: PC, stage registers, bypass muxes,
// data memory port and writeback
// ##########################################################################

`timescale 1ns/10ps

module lc4_processor import lc4_pkg::*; (
   input  logic  gwe,               // Pipeline clock
   input  logic  i_arst_n,
   output word_t o_cur_pc,          // Instruction memory address
   input  word_t i_cur_insn,        // Instruction at o_cur_pc, same cycle
   output word_t o_dmem_addr,
   input  word_t i_cur_dmem_data,   // Data at o_dmem_addr, same cycle
   output logic  o_dmem_we,
   output word_t o_dmem_towrite
);

   word_t    pc;
   logic     stall;

   // Decode
   word_t    d_insn;
   reg_sel_t d_r1sel, d_r2sel, d_wsel;
   logic     d_r1re, d_r2re, d_regfile_we, d_is_load, d_is_store;
   word_t    d_rs, d_rt;

   // Execute
   word_t    x_insn;
   reg_sel_t x_r1sel, x_r2sel, x_wsel;
   logic     x_r1re, x_r2re, x_regfile_we, x_is_load, x_is_store;
   word_t    x_rs, x_rt;
   word_t    x_rs_byp, x_rt_byp;    // Operands after bypass
   word_t    x_alu;
   fwd_sel_t rs_fwd, rt_fwd;

   // Memory
   reg_sel_t m_r2sel, m_wsel;
   logic     m_regfile_we, m_is_load, m_is_store;
   word_t    m_alu, m_rt;
   logic     store_fwd_wb;

   // Writeback
   reg_sel_t w_wsel;
   logic     w_regfile_we, w_is_load;
   word_t    w_alu, w_dmem_data, w_wdata;

   // Fetch: PC and decode register hold together on a stall
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc     <= PC_RESET;
         d_insn <= NOP_INSN;
      end else if (!stall) begin
         pc     <= pc + 16'd1;     // No control flow, always sequential
         d_insn <= i_cur_insn;
      end
   end

   assign o_cur_pc = pc;

   lc4_decoder decoder_i (
      .i_insn       (d_insn),
      .o_r1sel      (d_r1sel),
      .o_r2sel      (d_r2sel),
      .o_wsel       (d_wsel),
      .o_r1re       (d_r1re),
      .o_r2re       (d_r2re),
      .o_regfile_we (d_regfile_we),
      .o_is_load    (d_is_load),
      .o_is_store   (d_is_store)
   );

   lc4_regfile regfile_i (
      .gwe       (gwe),
      .i_arst_n  (i_arst_n),
      .i_rs      (d_r1sel),
      .i_rt      (d_r2sel),
      .i_rd      (w_wsel),
      .i_wdata   (w_wdata),
      .i_rd_we   (w_regfile_we),
      .o_rs_data (d_rs),
      .o_rt_data (d_rt)
   );

   lc4_hazard_unit hazard_i (
      .gwe            (gwe),
      .i_arst_n       (i_arst_n),
      .i_d_r1sel      (d_r1sel),
      .i_d_r2sel      (d_r2sel),
      .i_d_r1re       (d_r1re),
      .i_d_r2re       (d_r2re),
      .i_d_is_store   (d_is_store),
      .i_x_r1sel      (x_r1sel),
      .i_x_r2sel      (x_r2sel),
      .i_x_wsel       (x_wsel),
      .i_x_r1re       (x_r1re),
      .i_x_r2re       (x_r2re),
      .i_x_is_load    (x_is_load),
      .i_m_r2sel      (m_r2sel),
      .i_m_wsel       (m_wsel),
      .i_m_regfile_we (m_regfile_we),
      .i_m_is_load    (m_is_load),
      .i_m_is_store   (m_is_store),
      .i_w_wsel       (w_wsel),
      .i_w_regfile_we (w_regfile_we),
      .o_stall        (stall),
      .o_rs_fwd       (rs_fwd),
      .o_rt_fwd       (rt_fwd),
      .o_store_fwd_wb (store_fwd_wb)
   );

   // Stage control, a stall turns the execute entry into a bubble
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         x_insn       <= NOP_INSN;
         x_r1sel      <= '0;
         x_r2sel      <= '0;
         x_wsel       <= '0;
         x_r1re       <= 1'b0;
         x_r2re       <= 1'b0;
         x_regfile_we <= 1'b0;
         x_is_load    <= 1'b0;
         x_is_store   <= 1'b0;
         m_r2sel      <= '0;
         m_wsel       <= '0;
         m_regfile_we <= 1'b0;
         m_is_load    <= 1'b0;
         m_is_store   <= 1'b0;
         w_wsel       <= '0;
         w_regfile_we <= 1'b0;
         w_is_load    <= 1'b0;
      end else begin
         x_insn       <= stall ? NOP_INSN : d_insn;
         x_r1sel      <= d_r1sel;
         x_r2sel      <= d_r2sel;
         x_wsel       <= d_wsel;
         x_r1re       <= d_r1re & ~stall;
         x_r2re       <= d_r2re & ~stall;
         x_regfile_we <= d_regfile_we & ~stall;
         x_is_load    <= d_is_load & ~stall;
         x_is_store   <= d_is_store & ~stall;
         m_r2sel      <= x_r2sel;
         m_wsel       <= x_wsel;
         m_regfile_we <= x_regfile_we;
         m_is_load    <= x_is_load;
         m_is_store   <= x_is_store;
         w_wsel       <= m_wsel;
         w_regfile_we <= m_regfile_we;
         w_is_load    <= m_is_load;
      end
   end

   // Data path registers
   always_ff @(posedge gwe) begin
      x_rs        <= d_rs;
      x_rt        <= d_rt;
      m_alu       <= x_alu;
      m_rt        <= x_rt_byp;        // Store data after execute bypass
      w_alu       <= m_alu;
      w_dmem_data <= i_cur_dmem_data; // Load data for writeback
   end

   // Execute bypass muxes, memory stage has priority
   always_comb begin
      case (rs_fwd)
         FWD_MEM: x_rs_byp = m_alu;
         FWD_WB:  x_rs_byp = w_wdata;
         default: x_rs_byp = x_rs;
      endcase
      case (rt_fwd)
         FWD_MEM: x_rt_byp = m_alu;
         FWD_WB:  x_rt_byp = w_wdata;
         default: x_rt_byp = x_rt;
      endcase
   end

   lc4_alu alu_i (
      .i_insn   (x_insn),
      .i_r1data (x_rs_byp),
      .i_r2data (x_rt_byp),
      .o_result (x_alu)
   );

   // Memory port, idle outputs read as zero
   assign o_dmem_we      = m_is_store;
   assign o_dmem_addr    = (m_is_load || m_is_store) ? m_alu : '0;
   assign o_dmem_towrite = !m_is_store ? '0 : (store_fwd_wb ? w_wdata : m_rt);

   assign w_wdata = w_is_load ? w_dmem_data : w_alu;

   // A write needs a resolved address
   a_store_addr_known: assert property (
      @(posedge gwe) disable iff (!i_arst_n)
      o_dmem_we |-> !$isunknown(o_dmem_addr)
   ) else $error("Data memory write to an unknown address");

endmodule

// ==== tb_lc4_processor.sv ====
// ############################################################################
// LC4 pipeline testbench with clock, reset, random program, memory
// models, sequential ISA model, fetch, store and memory port checks
// ############################################################################

`timescale 1ns/10ps

module tb_lc4_processor import lc4_pkg::*; ();

   localparam int PROG_LEN   = 256;
   localparam int NUM_INSN   = PROG_LEN + 8 + 4;     // Program, closing stores, NOP tail
   localparam int SEED       = 32'h5218;
   localparam int PERIOD     = 40;
   localparam int MAX_CYCLES = 2 * PROG_LEN + 50;
   localparam int TRACE_MAX  = 1024;

   // Memory stage content per cycle
   localparam logic [1:0] MEM_NONE  = 2'd0;
   localparam logic [1:0] MEM_LOAD  = 2'd1;
   localparam logic [1:0] MEM_STORE = 2'd2;

   logic  gwe = 1'b0;
   logic  i_arst_n;
   word_t i_cur_insn, i_cur_dmem_data;
   word_t o_cur_pc, o_dmem_addr, o_dmem_towrite;
   logic  o_dmem_we;

   word_t      imem [65536];
   word_t      dmem [65536];
   word_t      model_mem [65536];        // Model's own copy of the data memory
   word_t      exp_pc [TRACE_MAX];
   logic [1:0] exp_kind [TRACE_MAX];
   word_t      exp_addr [TRACE_MAX];
   word_t      st_addr [$];
   word_t      st_data [$];
   int         trace_len;
   int         st_idx;
   int         cyc;
   logic       running;

   lc4_processor lc4_processor_i (
      .gwe             (gwe),
      .i_arst_n        (i_arst_n),
      .o_cur_pc        (o_cur_pc),
      .i_cur_insn      (i_cur_insn),
      .o_dmem_addr     (o_dmem_addr),
      .i_cur_dmem_data (i_cur_dmem_data),
      .o_dmem_we       (o_dmem_we),
      .o_dmem_towrite  (o_dmem_towrite)
   );

   initial begin
      forever #(PERIOD / 2) gwe = ~gwe;
   end

   // Combinational memory reads
   assign i_cur_insn      = imem[o_cur_pc];
   assign i_cur_dmem_data = dmem[o_dmem_addr];

   // Store lands at the closing edge
   always @(posedge gwe) begin
      if (o_dmem_we) begin
         dmem[o_dmem_addr] <= o_dmem_towrite;
      end
   end

   task automatic check_value(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         $display("ERROR %s: expected %h, actual %h", name, expected, actual);
         $display("TESTBENCH FAILED");
         $fatal(1, "Mismatch in %s", name);
      end
   endtask

   function automatic word_t sext(input word_t v, input int bits);
      word_t s;
      s = v << (16 - bits);                 // Field sign bit to bit 15
      return $signed(s) >>> (16 - bits);
   endfunction

   function automatic reg_sel_t pick_src(input reg_sel_t last_rd);
      if ($urandom_range(0, 1) == 1) begin
         return last_rd;                    // Back-to-back dependency
      end
      return reg_sel_t'($urandom_range(0, 7));
   endfunction

   task automatic gen_program();
      reg_sel_t rd, rs, rt, last_rd;
      word_t    insn;
      int       kind;
      last_rd = '0;
      for (int a = 0; a < 65536; a++) begin
         imem[a]      = NOP_INSN;
         dmem[a]      = word_t'($urandom);
         model_mem[a] = dmem[a];
      end
      for (int j = 0; j < PROG_LEN; j++) begin
         rd   = reg_sel_t'($urandom_range(0, 7));
         rs   = pick_src(last_rd);
         rt   = pick_src(last_rd);
         kind = $urandom_range(0, 15);
         case (kind)                        // Loads and stores weighted up
            0, 1, 2:  insn = {OP_LDR, rd, rs, 6'($urandom)};
            3, 4, 5:  insn = {OP_STR, rt, rs, 6'($urandom)};
            6:        insn = {OP_ARITH, rd, rs, 3'($urandom_range(0, 2)), rt};
            7:        insn = {OP_ARITH, rd, rs, 1'b1, 5'($urandom)};
            8:        insn = {OP_LOGIC, rd, rs, 3'($urandom_range(0, 3)), rt};
            9:        insn = {OP_LOGIC, rd, rs, 1'b1, 5'($urandom)};
            10, 11:   insn = {OP_SHIFT, rd, rs, 2'($urandom_range(0, 2)), 4'($urandom)};
            12, 13:   insn = {OP_CONST, rd, 9'($urandom)};
            default:  insn = {OP_HICONST, rs, 1'b1, 8'($urandom)};   // Reads and writes rs
         endcase
         imem[PC_RESET + j] = insn;
         if (insn[15:12] != OP_STR) begin
            last_rd = insn[11:9];
         end
      end
      // Dump r0..r7 with r7 as the base, stored last
      for (int r = 0; r < 8; r++) begin
         imem[PC_RESET + PROG_LEN + r] = {OP_STR, 3'(r), 3'd7, 6'(r)};
      end
   endtask

   task automatic run_model();
      word_t    regs [8];
      word_t    insn, a, b, res, addr;
      reg_sel_t r1, r2, rd, prev_rd;
      logic     r1re, r2re, we, ld, st, prev_ld, stall;
      int       c, n;
      for (int r = 0; r < 8; r++) begin
         regs[r] = '0;
      end
      for (int t = 0; t < TRACE_MAX; t++) begin
         exp_kind[t] = MEM_NONE;            // Bubbles unless filled below
         exp_addr[t] = '0;
      end
      prev_ld   = 1'b0;
      prev_rd   = '0;
      exp_pc[0] = PC_RESET;
      c         = 1;                        // First decode cycle
      for (int j = 0; j < NUM_INSN; j++) begin
         insn = imem[PC_RESET + j];
         rd   = insn[11:9];
         r1   = insn[8:6];
         r2   = insn[2:0];
         r1re = 1'b0;
         r2re = 1'b0;                       // Store data never counts for the stall
         we   = 1'b0;
         ld   = 1'b0;
         st   = 1'b0;
         addr = '0;
         res  = '0;
         a    = regs[r1];
         b    = regs[r2];
         case (insn[15:12])
            OP_ARITH: begin
               r1re = 1'b1;
               r2re = !insn[5];
               we   = 1'b1;
               if (insn[5]) res = a + sext(insn, 5);
               else if (insn[5:3] == ARITH_MUL) res = a * b;
               else if (insn[5:3] == ARITH_SUB) res = a - b;
               else res = a + b;
            end
            OP_LOGIC: begin
               r1re = 1'b1;
               r2re = !insn[5] && (insn[5:3] != LOGIC_NOT);
               we   = 1'b1;
               if (insn[5]) res = a & sext(insn, 5);
               else if (insn[5:3] == LOGIC_NOT) res = ~a;
               else if (insn[5:3] == LOGIC_OR) res = a | b;
               else if (insn[5:3] == LOGIC_XOR) res = a ^ b;
               else res = a & b;
            end
            OP_SHIFT: begin
               r1re = 1'b1;
               we   = 1'b1;
               case (insn[5:4])
                  SHIFT_SLL: res = a << insn[3:0];
                  SHIFT_SRA: res = sext(a >> insn[3:0], 16 - insn[3:0]);  // Refill sign
                  default:   res = a >> insn[3:0];
               endcase
            end
            OP_CONST: begin
               we  = 1'b1;
               res = sext(insn, 9);
            end
            OP_HICONST: begin
               r1   = rd;
               r1re = 1'b1;
               we   = 1'b1;
               res  = {insn[7:0], regs[rd][7:0]};
            end
            OP_LDR: begin
               r1re = 1'b1;
               we   = 1'b1;
               ld   = 1'b1;
               addr = a + sext(insn, 6);
               res  = model_mem[addr];
            end
            OP_STR: begin
               r1re = 1'b1;
               st   = 1'b1;
               addr = a + sext(insn, 6);
               model_mem[addr] = regs[rd];
               st_addr.push_back(addr);
               st_data.push_back(regs[rd]);
            end
            default: ;                      // NOP
         endcase
         stall = prev_ld && ((r1re && (r1 == prev_rd)) || (r2re && (r2 == prev_rd)));
         n = stall ? 2 : 1;
         for (int k = 0; k < n; k++) begin
            exp_pc[c + k] = PC_RESET + j + 1;   // Repeat on stall
         end
         exp_kind[c + n + 1] = ld ? MEM_LOAD : (st ? MEM_STORE : MEM_NONE);
         exp_addr[c + n + 1] = addr;
         c = c + n;
         if (we) begin
            regs[rd] = res;
         end
         prev_ld = ld;
         prev_rd = rd;
      end
      trace_len = c;
   endtask

   // Outputs settle well before the falling edge
   always @(negedge gwe) begin
      if (!running) begin
         check_value("reset_pc", PC_RESET, o_cur_pc);
         check_value("reset_dmem_we", 16'd0, {15'd0, o_dmem_we});
      end else begin
         if (cyc < trace_len) begin
            check_value("fetch_pc", exp_pc[cyc], o_cur_pc);
            case (exp_kind[cyc])
               MEM_LOAD: begin
                  check_value("load_dmem_we", 16'd0, {15'd0, o_dmem_we});
                  check_value("load_addr", exp_addr[cyc], o_dmem_addr);
                  check_value("load_towrite", 16'd0, o_dmem_towrite);
               end
               MEM_NONE: begin
                  check_value("idle_dmem_we", 16'd0, {15'd0, o_dmem_we});
                  check_value("idle_addr", 16'd0, o_dmem_addr);
                  check_value("idle_towrite", 16'd0, o_dmem_towrite);
               end
               default: ;                   // Store stream is followed below
            endcase
            if (o_dmem_we) begin
               if (st_idx >= st_addr.size()) begin
                  $display("A store was seen after all expected stores were used up");
                  $display("TESTBENCH FAILED");
                  $fatal(1, "Unexpected store");
               end
               check_value("store_addr", st_addr[st_idx], o_dmem_addr);
               check_value("store_data", st_data[st_idx], o_dmem_towrite);
               st_idx++;
            end
         end
         cyc++;
         if (cyc >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the program did not complete", cyc);
            $display("TESTBENCH FAILED");
            $fatal(1, "Timeout");
         end
      end
   end

   initial begin
      int unsigned seed_val;
      i_arst_n = 1'b0;
      running  = 1'b0;
      cyc      = 0;
      st_idx   = 0;
      seed_val = $urandom(SEED);
      gen_program();
      run_model();
      repeat (5) @(posedge gwe);
      i_arst_n <= 1'b1;
      running  = 1'b1;                      // Next falling edge is cycle 0
      wait (cyc >= trace_len);
      if (st_idx == st_addr.size()) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         $display("Only %0d of %0d expected stores were seen", st_idx, st_addr.size());
         $display("TESTBENCH FAILED");
         $fatal(1, "Store list not fully used");
      end
   end

endmodule

// ==== build.f ====
lc4_pkg.sv
lc4_decoder.sv
lc4_regfile.sv
lc4_alu.sv
lc4_hazard_unit.sv
lc4_processor.sv
tb_lc4_processor.sv

// ==== Bender.yml ====
package:
  name: lc4_pipeline

sources:
  - lc4_pkg.sv
  - lc4_decoder.sv
  - lc4_regfile.sv
  - lc4_alu.sv
  - lc4_hazard_unit.sv
  - lc4_processor.sv
  - target: test
    files:
      - tb_lc4_processor.sv
